/* rtl/ms_defines.svh */
// modular sequencer engine, global sizes and constants
// field width, prime, register file depth and microprogram entry points

`ifndef MS_DEFINES_SVH
`define MS_DEFINES_SVH

// ---------------------------------------------------------------------------
// datapath sizes
// ---------------------------------------------------------------------------
`define MS_WIDTH        16      // bits per field element
`define MS_PRIME        65521   // largest 16-bit prime

// ---------------------------------------------------------------------------
// register file
// ---------------------------------------------------------------------------
`define MS_REGS         8
`define MS_RADDR_W      3

// ---------------------------------------------------------------------------
// microprogram store
// ---------------------------------------------------------------------------
`define MS_PC_W         5       // 32 rom lines

// first rom line of each program
// spacing follows the program lengths in the rom, keep them in step
`define MS_BASE_MULADD  0       // 7 lines
`define MS_BASE_SQUARE  8       // 4 lines
`define MS_BASE_POLY    12      // 8 lines
`define MS_BASE_DIFFSQ  21      // 7 lines

`endif

/* rtl/ms_pkg.sv */
// modular sequencer engine, shared types
// word and address types, command and opcode encodings, microop layout,
// host operand bundle and controller states

package ms_pkg;

`include "ms_defines.svh"

    // ---------------------------------------------------------------------------
    // plain vectors
    // ---------------------------------------------------------------------------
    typedef logic [`MS_WIDTH-1:0]   ms_word_t;      // one field element
    typedef logic [`MS_RADDR_W-1:0] ms_raddr_t;     // register file index
    typedef logic [`MS_PC_W-1:0]    ms_pc_t;        // rom line

    // host commands
    typedef enum logic [1:0] {
        CMD_MULADD = 2'd0,      // a*b + c
        CMD_SQUARE = 2'd1,      // a*a
        CMD_POLY   = 2'd2,      // (a+b)*a + c
        CMD_DIFFSQ = 2'd3       // (a-b)*(a+b)
    } ms_cmd_e;

    // microcode operations
    typedef enum logic [2:0] {
        OP_NOP   = 3'd0,
        OP_LOAD  = 3'd1,        // src_a picks host operand
        OP_ADD   = 3'd2,
        OP_SUB   = 3'd3,
        OP_MUL   = 3'd4,        // multi-cycle
        OP_STORE = 3'd5,        // src_a goes to the result
        OP_END   = 3'd6
    } ms_opcode_e;

    // one rom line, 12 bits
    typedef struct packed {
        ms_opcode_e opcode;
        ms_raddr_t  dst;
        ms_raddr_t  src_a;
        ms_raddr_t  src_b;
    } ms_uop_t;

    typedef struct packed {
        ms_word_t a;
        ms_word_t b;
        ms_word_t c;
    } ms_operands_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FETCH,
        ST_EXEC,
        ST_WAIT,
        ST_DONE
    } ms_state_e;

endpackage

/* rtl/ms_prog_cntr.sv */
// program counter
// loads the entry line of a command, then steps through the program

`timescale 1ns/1ps
`include "ms_defines.svh"

module ms_prog_cntr import ms_pkg::*; (
    input  logic    clk,
    input  logic    reset_n,
    input  logic    load_i,
    input  ms_cmd_e cmd_i,
    input  logic    step_i,
    output ms_pc_t  pc_o
);

    ms_pc_t pc_q;
    ms_pc_t base;

    // command to entry line
    always_comb begin
        case (cmd_i)
            CMD_MULADD: base = ms_pc_t'(`MS_BASE_MULADD);
            CMD_SQUARE: base = ms_pc_t'(`MS_BASE_SQUARE);
            CMD_POLY:   base = ms_pc_t'(`MS_BASE_POLY);
            CMD_DIFFSQ: base = ms_pc_t'(`MS_BASE_DIFFSQ);
            default:    base = ms_pc_t'(`MS_BASE_MULADD);
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            pc_q <= '0;
        end else if (load_i) begin
            pc_q <= base;
        end else if (step_i) begin
            pc_q <= pc_q + ms_pc_t'(1);
        end
    end

    assign pc_o = pc_q;     // straight into the rom address

endmodule

/* rtl/ms_prog_rom.sv */
// microprogram store
// holds the four command programs, one registered read per cycle

`timescale 1ns/1ps
`include "ms_defines.svh"

module ms_prog_rom import ms_pkg::*; (
    input  logic    clk,
    input  ms_pc_t  addr_i,
    output ms_uop_t uop_o
);

    // register names
    localparam ms_raddr_t R0 = 3'd0;
    localparam ms_raddr_t R1 = 3'd1;
    localparam ms_raddr_t R2 = 3'd2;
    localparam ms_raddr_t R3 = 3'd3;   // working register
    localparam ms_raddr_t R4 = 3'd4;

    // host operand select for loads
    localparam ms_raddr_t SEL_A = 3'd0;
    localparam ms_raddr_t SEL_B = 3'd1;
    localparam ms_raddr_t SEL_C = 3'd2;

    function automatic ms_uop_t mk(ms_opcode_e op, ms_raddr_t dst, ms_raddr_t sa,
                                   ms_raddr_t sb);
        ms_uop_t u;
        u.opcode = op;
        u.dst    = dst;
        u.src_a  = sa;
        u.src_b  = sb;
        return u;
    endfunction

    always_ff @(posedge clk) begin
        case (addr_i)
            // muladd
            `MS_BASE_MULADD + 0: uop_o <= mk(OP_LOAD,  R0, SEL_A, R0);
            `MS_BASE_MULADD + 1: uop_o <= mk(OP_LOAD,  R1, SEL_B, R0);
            `MS_BASE_MULADD + 2: uop_o <= mk(OP_LOAD,  R2, SEL_C, R0);
            `MS_BASE_MULADD + 3: uop_o <= mk(OP_MUL,   R3, R0,    R1);
            `MS_BASE_MULADD + 4: uop_o <= mk(OP_ADD,   R3, R3,    R2);
            `MS_BASE_MULADD + 5: uop_o <= mk(OP_STORE, R0, R3,    R0);
            `MS_BASE_MULADD + 6: uop_o <= mk(OP_END,   R0, R0,    R0);
            // square
            `MS_BASE_SQUARE + 0: uop_o <= mk(OP_LOAD,  R0, SEL_A, R0);
            `MS_BASE_SQUARE + 1: uop_o <= mk(OP_MUL,   R3, R0,    R0);
            `MS_BASE_SQUARE + 2: uop_o <= mk(OP_STORE, R0, R3,    R0);
            `MS_BASE_SQUARE + 3: uop_o <= mk(OP_END,   R0, R0,    R0);
            // poly, horner form
            `MS_BASE_POLY + 0:   uop_o <= mk(OP_LOAD,  R0, SEL_A, R0);
            `MS_BASE_POLY + 1:   uop_o <= mk(OP_LOAD,  R1, SEL_B, R0);
            `MS_BASE_POLY + 2:   uop_o <= mk(OP_LOAD,  R2, SEL_C, R0);
            `MS_BASE_POLY + 3:   uop_o <= mk(OP_ADD,   R3, R0,    R1); // a+b
            `MS_BASE_POLY + 4:   uop_o <= mk(OP_MUL,   R3, R3,    R0); // (a+b)*a
            `MS_BASE_POLY + 5:   uop_o <= mk(OP_ADD,   R3, R3,    R2);
            `MS_BASE_POLY + 6:   uop_o <= mk(OP_STORE, R0, R3,    R0);
            `MS_BASE_POLY + 7:   uop_o <= mk(OP_END,   R0, R0,    R0);
            // diffsq
            `MS_BASE_DIFFSQ + 0: uop_o <= mk(OP_LOAD,  R0, SEL_A, R0);
            `MS_BASE_DIFFSQ + 1: uop_o <= mk(OP_LOAD,  R1, SEL_B, R0);
            `MS_BASE_DIFFSQ + 2: uop_o <= mk(OP_SUB,   R3, R0,    R1);
            `MS_BASE_DIFFSQ + 3: uop_o <= mk(OP_ADD,   R4, R0,    R1);
            `MS_BASE_DIFFSQ + 4: uop_o <= mk(OP_MUL,   R3, R3,    R4);
            `MS_BASE_DIFFSQ + 5: uop_o <= mk(OP_STORE, R0, R3,    R0);
            `MS_BASE_DIFFSQ + 6: uop_o <= mk(OP_END,   R0, R0,    R0);
            default:             uop_o <= mk(OP_NOP,   R0, R0,    R0); // gaps
        endcase
    end

endmodule

/* rtl/ms_arith_unit.sv */
// modular arithmetic unit
// eight-word register file with add, sub and an iterative shift-add
// multiplier, all reduced mod the prime

`timescale 1ns/1ps
`include "ms_defines.svh"

module ms_arith_unit import ms_pkg::*; (
    input  logic         clk,
    input  logic         reset_n,
    input  ms_uop_t      uop_i,
    input  logic         uop_valid_i,
    input  ms_operands_t operands_i,
    output logic         busy_o,
    output ms_word_t     rd_data_o
);

    localparam logic [`MS_WIDTH:0] PRIME_X = `MS_PRIME;   // one guard bit
    localparam int CNT_W = $clog2(`MS_WIDTH);

    ms_word_t regs [`MS_REGS];

    ms_word_t op_a;
    ms_word_t op_b;
    ms_word_t load_val;

    // multiplier state
    logic             mul_busy_q;
    logic [CNT_W-1:0] mul_cnt_q;
    ms_word_t         mul_a_q;      // multiplicand
    ms_word_t         mul_b_q;      // multiplier, msb first
    ms_word_t         mul_acc_q;
    ms_raddr_t        mul_dst_q;
    ms_word_t         mul_dbl;
    ms_word_t         mul_next;
    logic             mul_start;
    logic             mul_last;

    // ---------------------------------------------------------------------------
    // modular helpers, inputs already below P
    // ---------------------------------------------------------------------------
    function automatic ms_word_t mod_add(ms_word_t x, ms_word_t y);
        logic [`MS_WIDTH:0] s;
        s = {1'b0, x} + {1'b0, y};
        if (s >= PRIME_X)
            s = s - PRIME_X;
        return s[`MS_WIDTH-1:0];
    endfunction

    function automatic ms_word_t mod_sub(ms_word_t x, ms_word_t y);
        logic [`MS_WIDTH:0] d;
        d = {1'b0, x} - {1'b0, y};
        if (d[`MS_WIDTH])           // borrow
            d = d + PRIME_X;
        return d[`MS_WIDTH-1:0];
    endfunction

    assign op_a      = regs[uop_i.src_a];
    assign op_b      = regs[uop_i.src_b];
    assign rd_data_o = op_a;        // read port for stores

    always_comb begin
        case (uop_i.src_a)
            3'd0:    load_val = operands_i.a;
            3'd1:    load_val = operands_i.b;
            default: load_val = operands_i.c;
        endcase
    end

    // ---------------------------------------------------------------------------
    // interleaved multiply, acc = 2*acc (+ a)
    // ---------------------------------------------------------------------------
    assign mul_start = uop_valid_i && (uop_i.opcode == OP_MUL);
    assign mul_last  = (mul_cnt_q == CNT_W'(`MS_WIDTH - 1));
    assign mul_dbl   = mod_add(mul_acc_q, mul_acc_q);
    assign mul_next  = mul_b_q[`MS_WIDTH-1] ? mod_add(mul_dbl, mul_a_q) : mul_dbl;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            mul_busy_q <= 1'b0;
            mul_cnt_q  <= '0;
        end else if (mul_start) begin
            mul_busy_q <= 1'b1;
            mul_cnt_q  <= '0;
        end else if (mul_busy_q) begin
            mul_cnt_q <= mul_cnt_q + 1'b1;
            if (mul_last)
                mul_busy_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (mul_start) begin
            mul_a_q   <= op_a;      // latched, dst may equal a source
            mul_b_q   <= op_b;
            mul_acc_q <= '0;
            mul_dst_q <= uop_i.dst;
        end else if (mul_busy_q) begin
            mul_acc_q <= mul_next;
            mul_b_q   <= mul_b_q << 1;
        end
    end

    assign busy_o = mul_busy_q;

    // register file writes
    always_ff @(posedge clk) begin
        if (mul_busy_q && mul_last) begin
            regs[mul_dst_q] <= mul_next;
        end else if (uop_valid_i) begin
            case (uop_i.opcode)
                OP_LOAD: regs[uop_i.dst] <= load_val;
                OP_ADD:  regs[uop_i.dst] <= mod_add(op_a, op_b);
                OP_SUB:  regs[uop_i.dst] <= mod_sub(op_a, op_b);
                default: ;          // store, end, nop leave the file alone
            endcase
        end
    end

endmodule

/* rtl/ms_ctrl_fsm.sv */
// sequencing controller
// walks the microprogram, issues uops to the arithmetic unit, waits out
// multiplies, captures the stored result and drives host status

`timescale 1ns/1ps

module ms_ctrl_fsm import ms_pkg::*; (
    input  logic     clk,
    input  logic     reset_n,
    input  logic     start_i,
    input  ms_uop_t  uop_i,
    input  logic     arith_busy_i,
    input  ms_word_t rd_data_i,
    output logic     pc_load_o,
    output logic     pc_step_o,
    output logic     uop_valid_o,
    output logic     busy_o,
    output logic     done_o,
    output ms_word_t result_o
);

    ms_state_e state_q;
    ms_state_e state_d;
    ms_word_t  store_q;         // staged until the end of the program
    ms_word_t  result_q;

    // ---------------------------------------------------------------------------
    // next state and program counter control
    // ---------------------------------------------------------------------------
    always_comb begin
        state_d   = state_q;
        pc_load_o = 1'b0;
        pc_step_o = 1'b0;
        case (state_q)
            ST_IDLE: begin
                if (start_i) begin
                    pc_load_o = 1'b1;       // cmd_i sampled here
                    state_d   = ST_FETCH;
                end
            end
            ST_FETCH: begin
                state_d = ST_EXEC;          // rom read latency
            end
            ST_EXEC: begin
                case (uop_i.opcode)
                    OP_MUL: state_d = ST_WAIT;
                    OP_END: state_d = ST_DONE;
                    default: begin
                        pc_step_o = 1'b1;
                        state_d   = ST_FETCH;
                    end
                endcase
            end
            ST_WAIT: begin
                // busy comes up the cycle after issue, so never seen low early
                if (!arith_busy_i) begin
                    pc_step_o = 1'b1;
                    state_d   = ST_FETCH;
                end
            end
            ST_DONE: begin
                state_d = ST_IDLE;
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state_q  <= ST_IDLE;
            result_q <= '0;
        end else begin
            state_q <= state_d;
            // publish on the way to done so result_o only moves with done_o
            if (state_q == ST_EXEC && uop_i.opcode == OP_END)
                result_q <= store_q;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ST_EXEC && uop_i.opcode == OP_STORE)
            store_q <= rd_data_i;
    end

    // ---------------------------------------------------------------------------
    // status outputs
    // ---------------------------------------------------------------------------
    assign uop_valid_o = (state_q == ST_EXEC);
    assign busy_o      = (state_q == ST_FETCH) || (state_q == ST_EXEC) ||
                         (state_q == ST_WAIT);     // low again in done
    assign done_o      = (state_q == ST_DONE);
    assign result_o    = result_q;

endmodule

/* rtl/ms_core.sv */
// modular sequencer engine, top level
// program counter, microcode rom, arithmetic unit and controller

`timescale 1ns/1ps

module ms_core import ms_pkg::*; (
    input  logic         clk,
    input  logic         reset_n,
    input  logic         start_i,
    input  ms_cmd_e      cmd_i,
    input  ms_operands_t operands_i,
    output logic         busy_o,
    output logic         done_o,
    output ms_word_t     result_o
);

    logic     pc_load;
    logic     pc_step;
    ms_pc_t   pc;
    ms_uop_t  uop;
    logic     uop_valid;
    logic     arith_busy;
    ms_word_t rd_data;

    ms_prog_cntr u_prog_cntr (
        .clk     (clk),
        .reset_n (reset_n),
        .load_i  (pc_load),
        .cmd_i   (cmd_i),
        .step_i  (pc_step),
        .pc_o    (pc)
    );

    ms_prog_rom u_prog_rom (
        .clk    (clk),
        .addr_i (pc),
        .uop_o  (uop)
    );

    ms_arith_unit u_arith_unit (
        .clk         (clk),
        .reset_n     (reset_n),
        .uop_i       (uop),
        .uop_valid_i (uop_valid),
        .operands_i  (operands_i),      // held by the host while busy
        .busy_o      (arith_busy),
        .rd_data_o   (rd_data)
    );

    ms_ctrl_fsm u_ctrl_fsm (
        .clk          (clk),
        .reset_n      (reset_n),
        .start_i      (start_i),
        .uop_i        (uop),
        .arith_busy_i (arith_busy),
        .rd_data_i    (rd_data),
        .pc_load_o    (pc_load),
        .pc_step_o    (pc_step),
        .uop_valid_o  (uop_valid),
        .busy_o       (busy_o),
        .done_o       (done_o),
        .result_o     (result_o)
    );

endmodule

/* test/ms_core_asserts.sv */
// host port checks for the modular sequencer core
// bound into ms_core, flags pulse, overlap and range violations

`timescale 1ns/1ps
`include "ms_defines.svh"

module ms_core_asserts import ms_pkg::*; (
    input logic     clk,
    input logic     reset_n,
    input logic     start_i,
    input logic     busy_o,
    input logic     done_o,
    input ms_word_t result_o
);

    int n_fail = 0;     // failed assertions so far

    a_done_pulse: assert property (@(posedge clk) disable iff (!reset_n)
        done_o |=> !done_o)
        else begin
            $error("done_o stayed high for two cycles");
            n_fail++;
        end

    a_done_not_busy: assert property (@(posedge clk) disable iff (!reset_n)
        !(done_o && busy_o))
        else begin
            $error("done_o and busy_o high together");
            n_fail++;
        end

    // result must be a reduced field element
    a_result_range: assert property (@(posedge clk) disable iff (!reset_n)
        done_o |-> (result_o < `MS_PRIME))
        else begin
            $error("result_o not below the prime at done_o");
            n_fail++;
        end

    // idle is neither busy nor done
    a_start_busy: assert property (@(posedge clk) disable iff (!reset_n)
        (start_i && !busy_o && !done_o) |=> busy_o)
        else begin
            $error("accepted start did not raise busy_o");
            n_fail++;
        end

endmodule

bind ms_core ms_core_asserts u_asserts (
    .clk      (clk),
    .reset_n  (reset_n),
    .start_i  (start_i),
    .busy_o   (busy_o),
    .done_o   (done_o),
    .result_o (result_o)
);

/* test/ms_core_tb.sv */
// testbench for the modular sequencer core
// directed command runs against a mod-P reference model, with a
// cycle watchdog

`timescale 1ns/1ps
`include "ms_defines.svh"

module ms_core_tb import ms_pkg::*; ();

    localparam ms_word_t PM1       = ms_word_t'(`MS_PRIME - 1);
    localparam int NUM_CMDS        = 24 + 20 + 1 + 8;    // fixed, random, ignored, chain
    localparam int LONGEST_PROG    = 40;                 // poly with idle gaps
    localparam int CYCLE_LIMIT     = NUM_CMDS * LONGEST_PROG + 300;

    logic         clk = 1'b0;
    logic         reset_n;
    logic         start_i;
    ms_cmd_e      cmd_i;
    ms_operands_t operands_i;
    logic         busy_o;
    logic         done_o;
    ms_word_t     result_o;

    int          n_checks    = 0;
    int          value_errs  = 0;
    int          flag_errs   = 0;
    int          cycle_cnt   = 0;
    logic [31:0] lfsr_q      = 32'hfb82;
    ms_word_t    last_result = '0;     // expected result of the last run

    ms_core u_dut (
        .clk        (clk),
        .reset_n    (reset_n),
        .start_i    (start_i),
        .cmd_i      (cmd_i),
        .operands_i (operands_i),
        .busy_o     (busy_o),
        .done_o     (done_o),
        .result_o   (result_o)
    );

    always #10 clk = ~clk;

    // ------------------------------------------------------------------------
    // watchdog
    // ------------------------------------------------------------------------
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display(">>> FAIL");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // reference model, stimulus source and compare tasks
    // ------------------------------------------------------------------------
    function automatic ms_word_t model_result(ms_cmd_e cmd, ms_operands_t ops);
        logic [31:0] p;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] t;
        p = `MS_PRIME;
        a = 32'(ops.a);
        b = 32'(ops.b);
        c = 32'(ops.c);
        case (cmd)
            CMD_MULADD: t = ((a * b) % p + c) % p;
            CMD_SQUARE: t = (a * a) % p;
            CMD_POLY:   t = ((a * a) % p + (b * a) % p + c) % p;  // a^2 + ba + c
            default:    t = (((a + p - b) % p) * ((a + b) % p)) % p;
        endcase
        return ms_word_t'(t);
    endfunction

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic rand_word(output ms_word_t w);
        w = '0;
        for (int i = 0; i < `MS_WIDTH; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            w = {w[`MS_WIDTH-2:0], lfsr_q[0]};
        end
        if (w >= `MS_PRIME)
            w = w - ms_word_t'(`MS_PRIME);     // keep operands reduced
    endtask

    task automatic check_word(input string name, input ms_word_t got, input ms_word_t exp);
        n_checks++;
        if (got !== exp) begin
            value_errs++;
            $display("error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            flag_errs++;
            $display("error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    // ------------------------------------------------------------------------
    // host side helpers
    // ------------------------------------------------------------------------
    task automatic issue_start(input ms_cmd_e cmd, input ms_operands_t ops);
        @(posedge clk);
        start_i    <= 1'b1;
        cmd_i      <= cmd;
        operands_i <= ops;
        @(posedge clk);
        start_i    <= 1'b0;
    endtask

    // call at a falling edge; returns at the falling edge of the done cycle
    task automatic wait_done(output ms_word_t res);
        while (!done_o) begin
            check_bit("busy_o", busy_o, 1'b1);
            check_word("result_o held", result_o, last_result);
            @(negedge clk);
        end
        res = result_o;
    endtask

    task automatic run_and_check(input ms_cmd_e cmd, input ms_operands_t ops);
        ms_word_t res;
        ms_word_t exp;
        exp = model_result(cmd, ops);
        issue_start(cmd, ops);
        @(negedge clk);
        wait_done(res);
        check_word($sformatf("result_o (%s)", cmd.name()), res, exp);
        last_result = exp;
    endtask

    // ------------------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------------------
    task automatic reset_values();
        @(negedge clk);
        check_bit("busy_o", busy_o, 1'b0);
        check_bit("done_o", done_o, 1'b0);
        check_word("result_o", result_o, '0);
    endtask

    task automatic fixed_operand_cases();
        ms_operands_t sets [6];
        sets[0] = '{a: '0, b: '0, c: '0};
        sets[1] = '{a: 16'd1, b: 16'd1, c: 16'd1};
        sets[2] = '{a: PM1, b: PM1, c: PM1};
        sets[3] = '{a: PM1, b: 16'd1, c: '0};
        sets[4] = '{a: '0, b: PM1, c: 16'd1};    // a-b wraps around
        sets[5] = '{a: 16'd1234, b: 16'd56789, c: 16'd4321};
        foreach (sets[s])
            for (int k = 0; k < 4; k++)
                run_and_check(ms_cmd_e'(k), sets[s]);
    endtask

    task automatic random_operand_cases();
        ms_operands_t ops;
        for (int i = 0; i < 20; i++) begin
            rand_word(ops.a);
            rand_word(ops.b);
            rand_word(ops.c);
            run_and_check(ms_cmd_e'(i % 4), ops);
        end
    endtask

    task automatic busy_start_ignored();
        ms_operands_t ops;
        ms_word_t     res;
        ms_word_t     exp;
        ops = '{a: 16'd40000, b: 16'd30000, c: 16'd777};
        exp = model_result(CMD_MULADD, ops);
        issue_start(CMD_MULADD, ops);
        repeat (3) @(posedge clk);
        start_i <= 1'b1;            // second start mid-run, other command
        cmd_i   <= CMD_SQUARE;
        @(posedge clk);
        start_i <= 1'b0;
        @(negedge clk);
        wait_done(res);
        check_word("result_o (muladd, start ignored)", res, exp);
        last_result = exp;
        // no second run may follow
        repeat (45) begin
            @(negedge clk);
            check_bit("done_o", done_o, 1'b0);
            check_bit("busy_o", busy_o, 1'b0);
        end
    endtask

    // each start lands in the idle cycle right after done_o
    task automatic back_to_back_cmds();
        ms_operands_t ops;
        for (int i = 0; i < 8; i++) begin
            rand_word(ops.a);
            rand_word(ops.b);
            rand_word(ops.c);
            run_and_check(ms_cmd_e'(3 - (i % 4)), ops);
        end
    endtask

    initial begin
        reset_n    = 1'b0;
        start_i    = 1'b0;
        cmd_i      = CMD_MULADD;
        operands_i = '0;
        repeat (5) @(posedge clk);
        reset_n <= 1'b1;

        reset_values();
        fixed_operand_cases();
        random_operand_cases();
        busy_start_ignored();
        back_to_back_cmds();

        $display("checks %0d, value errors %0d, flag errors %0d, assertion errors %0d",
                 n_checks, value_errs, flag_errs, u_dut.u_asserts.n_fail);
        if (value_errs == 0 && flag_errs == 0 && u_dut.u_asserts.n_fail == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

/* src.f */
+incdir+rtl
rtl/ms_pkg.sv
rtl/ms_prog_cntr.sv
rtl/ms_prog_rom.sv
rtl/ms_arith_unit.sv
rtl/ms_ctrl_fsm.sv
rtl/ms_core.sv
test/ms_core_asserts.sv
test/ms_core_tb.sv

/* Bender.yml */
package:
  name: ms_core

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/ms_pkg.sv
      - rtl/ms_prog_cntr.sv
      - rtl/ms_prog_rom.sv
      - rtl/ms_arith_unit.sv
      - rtl/ms_ctrl_fsm.sv
      - rtl/ms_core.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/ms_core_asserts.sv
      - test/ms_core_tb.sv
